/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_mem_rd
FILELIST  := tb.f
OBJDIR    := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* rtl/mem_array.sv */
`timescale 1ns/1ps

module mem_array #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rd_en,
    input  logic [memrd_pkg::ADDR_W-1:0] rd_addr,   // byte address
    input  logic                         wr_en,
    input  logic [memrd_pkg::ADDR_W-1:0] wr_addr,   // word index
    input  logic [memrd_pkg::XLEN-1:0]   wr_data,
    output logic [memrd_pkg::XLEN-1:0]   rd_word,
    output logic                         rd_error
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int WIDX_W = memrd_pkg::ADDR_W - 3;

    logic [memrd_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [WIDX_W-1:0]          rd_idx;
    logic                       rd_in_range;
    logic                       wr_in_range;

    assign rd_idx      = rd_addr[memrd_pkg::ADDR_W-1:3];  // offset bits dropped
    assign rd_in_range = (rd_idx < WIDX_W'(MEM_WORDS));
    assign wr_in_range = (wr_addr < memrd_pkg::ADDR_W'(MEM_WORDS));

    // preload sideband, out of range writes fall on the floor
    always_ff @(posedge clk) begin
        if (wr_en && wr_in_range) begin
            mem[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= rd_in_range ? mem[rd_idx[IDX_W-1:0]] : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_error <= 1'b0;
        end else if (rd_en) begin
            rd_error <= !rd_in_range;
        end
    end

endmodule

/* rtl/mem_rd_top.sv */
`timescale 1ns/1ps

module mem_rd_top #(
    parameter int MEM_WORDS   = 256,
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // fetch request
    input  logic                         fetch_req_valid,
    input  logic [memrd_pkg::ADDR_W-1:0] fetch_req_pc,
    output logic                         fetch_req_credit,
    // load request
    input  logic                         load_req_valid,
    input  logic [memrd_pkg::ADDR_W-1:0] load_req_addr,
    input  memrd_pkg::mem_op_e           load_req_op,
    output logic                         load_req_credit,
    // fetch response
    output logic                         fetch_rsp_valid,
    output logic [31:0]                  fetch_rsp_instr,
    output logic                         fetch_rsp_error,
    input  logic                         fetch_rsp_credit,
    // load response
    output logic                         load_rsp_valid,
    output logic [memrd_pkg::XLEN-1:0]   load_rsp_data,
    output logic                         load_rsp_error,
    input  logic                         load_rsp_credit,
    // preload sideband
    input  logic                         mem_wr_en,
    input  logic [memrd_pkg::ADDR_W-1:0] mem_wr_addr,
    input  logic [memrd_pkg::XLEN-1:0]   mem_wr_data
);

    localparam int LOAD_W = memrd_pkg::ADDR_W + 3;  // {op, addr}

    logic                         fetch_empty;
    logic                         load_empty;
    logic                         fetch_pop;
    logic                         load_pop;
    logic [memrd_pkg::ADDR_W-1:0] fetch_head_pc;
    logic [LOAD_W-1:0]            load_head;
    logic                         issue_valid;
    memrd_pkg::chan_e             issue_chan;
    logic [memrd_pkg::ADDR_W-1:0] issue_addr;
    memrd_pkg::mem_op_e           issue_op;
    logic [memrd_pkg::XLEN-1:0]   rd_word;
    logic                         rd_error;

    assign fetch_req_credit = fetch_pop;  // a pop frees one queue slot
    assign load_req_credit  = load_pop;

    req_fifo #(.DEPTH(REQ_DEPTH), .WIDTH(memrd_pkg::ADDR_W)) u_fetch_q (
        .clk(clk), .rst_n(rst_n),
        .push(fetch_req_valid), .push_data(fetch_req_pc),
        .pop(fetch_pop), .head_data(fetch_head_pc), .empty(fetch_empty)
    );

    req_fifo #(.DEPTH(REQ_DEPTH), .WIDTH(LOAD_W)) u_load_q (
        .clk(clk), .rst_n(rst_n),
        .push(load_req_valid), .push_data({load_req_op, load_req_addr}),
        .pop(load_pop), .head_data(load_head), .empty(load_empty)
    );

    rd_ctrl #(.RSP_CREDITS(RSP_CREDITS)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .fetch_empty(fetch_empty), .load_empty(load_empty),
        .fetch_head_pc(fetch_head_pc),
        .load_head_addr(load_head[memrd_pkg::ADDR_W-1:0]),
        .load_head_op(memrd_pkg::mem_op_e'(load_head[LOAD_W-1:memrd_pkg::ADDR_W])),
        .fetch_rsp_credit(fetch_rsp_credit), .load_rsp_credit(load_rsp_credit),
        .fetch_pop(fetch_pop), .load_pop(load_pop),
        .issue_valid(issue_valid), .issue_chan(issue_chan),
        .issue_addr(issue_addr), .issue_op(issue_op)
    );

    mem_array #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .rd_en(issue_valid), .rd_addr(issue_addr),
        .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_word(rd_word), .rd_error(rd_error)
    );

    rsp_format u_fmt (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_chan(issue_chan),
        .issue_addr(issue_addr), .issue_op(issue_op),
        .rd_word(rd_word), .rd_error(rd_error),
        .fetch_rsp_valid(fetch_rsp_valid), .fetch_rsp_instr(fetch_rsp_instr),
        .fetch_rsp_error(fetch_rsp_error),
        .load_rsp_valid(load_rsp_valid), .load_rsp_data(load_rsp_data),
        .load_rsp_error(load_rsp_error)
    );

endmodule

/* rtl/memrd_pkg.sv */
package memrd_pkg;

    // ########################################
    // widths
    // ########################################
    localparam int ADDR_W = 64;  // byte address
    localparam int XLEN   = 64;  // memory word and load result

    // ########################################
    // load opcodes
    // ########################################
    // bit 2 set means zero extend, low bits give log2 of the size
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } mem_op_e;

    // channel of an issued read
    typedef enum logic {
        chan_fetch = 1'b0,
        chan_load  = 1'b1
    } chan_e;

    // round robin pointer of the read arbiter
    typedef enum logic {
        favor_fetch = 1'b0,
        favor_load  = 1'b1
    } arb_state_e;

endpackage

/* rtl/rd_ctrl.sv */
`timescale 1ns/1ps

module rd_ctrl #(
    parameter int RSP_CREDITS = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            fetch_empty,
    input  logic                            load_empty,
    input  logic [memrd_pkg::ADDR_W-1:0]    fetch_head_pc,
    input  logic [memrd_pkg::ADDR_W-1:0]    load_head_addr,
    input  memrd_pkg::mem_op_e              load_head_op,
    input  logic                            fetch_rsp_credit,
    input  logic                            load_rsp_credit,
    output logic                            fetch_pop,
    output logic                            load_pop,
    output logic                            issue_valid,
    output memrd_pkg::chan_e                issue_chan,
    output logic [memrd_pkg::ADDR_W-1:0]    issue_addr,
    output memrd_pkg::mem_op_e              issue_op
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0]      fetch_rsp_cnt;  // response slots left per channel
    logic [CNT_W-1:0]      load_rsp_cnt;
    memrd_pkg::arb_state_e arb_state;
    logic                  fetch_elig;
    logic                  load_elig;

    // ########################################
    // channel select
    // ########################################
    assign fetch_elig = !fetch_empty && (fetch_rsp_cnt != '0);
    assign load_elig  = !load_empty && (load_rsp_cnt != '0);

    always_comb begin
        fetch_pop = 1'b0;
        load_pop  = 1'b0;
        if (fetch_elig && load_elig) begin
            // both want the port, round robin decides
            if (arb_state == memrd_pkg::favor_fetch) begin
                fetch_pop = 1'b1;
            end else begin
                load_pop = 1'b1;
            end
        end else begin
            fetch_pop = fetch_elig;
            load_pop  = load_elig;
        end
    end

    assign issue_valid = fetch_pop || load_pop;
    assign issue_chan  = load_pop ? memrd_pkg::chan_load : memrd_pkg::chan_fetch;
    assign issue_addr  = load_pop ? load_head_addr : fetch_head_pc;
    assign issue_op    = load_pop ? load_head_op : memrd_pkg::ld;  // fetch reads the full word

    // ########################################
    // credits and arbiter state
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_rsp_cnt <= CNT_W'(RSP_CREDITS);
            load_rsp_cnt  <= CNT_W'(RSP_CREDITS);
        end else begin
            fetch_rsp_cnt <= fetch_rsp_cnt - CNT_W'(fetch_pop) + CNT_W'(fetch_rsp_credit);
            load_rsp_cnt  <= load_rsp_cnt - CNT_W'(load_pop) + CNT_W'(load_rsp_credit);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_state <= memrd_pkg::favor_fetch;
        end else if (fetch_pop) begin
            arb_state <= memrd_pkg::favor_load;  // winner goes to the back
        end else if (load_pop) begin
            arb_state <= memrd_pkg::favor_fetch;
        end
    end

endmodule

/* rtl/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] slots [DEPTH];  // no reset on payload
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointer step with wrap at DEPTH-1
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // the sender's credits keep count at or below DEPTH
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign head_data = slots[rd_ptr];  // visible the cycle after the push
    assign empty     = (count == '0);

endmodule

/* rtl/rsp_format.sv */
`timescale 1ns/1ps

module rsp_format (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         issue_valid,
    input  memrd_pkg::chan_e             issue_chan,
    input  logic [memrd_pkg::ADDR_W-1:0] issue_addr,
    input  memrd_pkg::mem_op_e           issue_op,
    input  logic [memrd_pkg::XLEN-1:0]   rd_word,
    input  logic                         rd_error,
    output logic                         fetch_rsp_valid,
    output logic [31:0]                  fetch_rsp_instr,
    output logic                         fetch_rsp_error,
    output logic                         load_rsp_valid,
    output logic [memrd_pkg::XLEN-1:0]   load_rsp_data,
    output logic                         load_rsp_error
);

    logic               valid_q;
    memrd_pkg::chan_e   chan_q;
    memrd_pkg::mem_op_e op_q;
    logic [2:0]         off_q;  // byte offset in the word
    logic [7:0]         lane_b;
    logic [15:0]        lane_h;
    logic [31:0]        lane_w;

    // ########################################
    // issue context
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;  // one cycle pulse, never held
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            chan_q <= issue_chan;
            op_q   <= issue_op;
            off_q  <= issue_addr[2:0];
        end
    end

    // ########################################
    // fetch
    // ########################################
    assign fetch_rsp_valid = valid_q && (chan_q == memrd_pkg::chan_fetch);
    assign fetch_rsp_instr = off_q[2] ? rd_word[63:32] : rd_word[31:0];  // pc bit 2
    assign fetch_rsp_error = rd_error;

    // ########################################
    // load lanes and extension
    // ########################################
    // byte exact, half drops bit 0, word drops bits 1 and 0
    assign lane_b = rd_word[{off_q, 3'b000} +: 8];
    assign lane_h = rd_word[{off_q[2:1], 4'b0000} +: 16];
    assign lane_w = off_q[2] ? rd_word[63:32] : rd_word[31:0];

    always_comb begin
        case (op_q)
            memrd_pkg::lb:  load_rsp_data = {{56{lane_b[7]}}, lane_b};
            memrd_pkg::lbu: load_rsp_data = {56'h0, lane_b};
            memrd_pkg::lh:  load_rsp_data = {{48{lane_h[15]}}, lane_h};
            memrd_pkg::lhu: load_rsp_data = {48'h0, lane_h};
            memrd_pkg::lw:  load_rsp_data = {{32{lane_w[31]}}, lane_w};
            memrd_pkg::lwu: load_rsp_data = {32'h0, lane_w};
            default:        load_rsp_data = rd_word;  // ld, offset ignored
        endcase
    end

    assign load_rsp_valid = valid_q && (chan_q == memrd_pkg::chan_load);
    assign load_rsp_error = rd_error;  // data already zero from the array

endmodule

/* sim/mem_rd_cases.txt */
# columns: W word_index data | F pc count | L op addr count (numbers in hex)
# count repeats a request, fetch pc steps by 4 and load addr by 1
W 000 8877665544332211
W 001 fedcba9876543210
W 002 00000013fff00093
W 003 80017fff8000ff80
W 0ff 0123456789abcdef
W 100 deadbeefdeadbeef
F 000 4
F 010 2
L lb 008 8
L lbu 008 8
L lh 008 8
L lhu 008 8
L lw 008 8
L lwu 008 8
L ld 008 8
F 800 1
L ld 800 1
L lw 7fc 1
L lbu 7ff 1
F 7f8 2
L lb 1000 1
F ffffffffffffffff 1
F 008 2
L lh 000 8
L lw 018 8
L lh 018 8
L lb 018 8
L lwu 018 8
L ld 000 1
F 1000 1
L ld 7f8 1
L lhu 010 8
L lbu 018 8
F 000 3

/* sim/mem_rd_checker.sv */
`timescale 1ns/1ps

module mem_rd_checker #(
    parameter int RSP_CREDITS = 2
) (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 issue_valid,
    input memrd_pkg::chan_e                     issue_chan,
    input logic [$clog2(RSP_CREDITS + 1)-1:0]   fetch_rsp_cnt,
    input logic [$clog2(RSP_CREDITS + 1)-1:0]   load_rsp_cnt,
    input logic                                 fetch_rsp_valid,
    input logic                                 load_rsp_valid
);

    // ########################################
    // response credits
    // ########################################
    a_fetch_credit: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && issue_chan == memrd_pkg::chan_fetch |-> fetch_rsp_cnt != '0)
        else $error("fetch read issued with no response credit");

    a_load_credit: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && issue_chan == memrd_pkg::chan_load |-> load_rsp_cnt != '0)
        else $error("load read issued with no response credit");

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp_cnt <= RSP_CREDITS && load_rsp_cnt <= RSP_CREDITS)
        else $error("response credit counter above its limit");

    // ########################################
    // response valids
    // ########################################
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !fetch_rsp_valid && !load_rsp_valid)
        else $error("response valid high during reset");

    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_rsp_valid && load_rsp_valid))
        else $error("fetch and load responses in the same cycle");

endmodule

bind mem_rd_top mem_rd_checker #(.RSP_CREDITS(RSP_CREDITS)) u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .issue_valid(issue_valid),
    .issue_chan(issue_chan),
    .fetch_rsp_cnt(u_ctrl.fetch_rsp_cnt),
    .load_rsp_cnt(u_ctrl.load_rsp_cnt),
    .fetch_rsp_valid(fetch_rsp_valid),
    .load_rsp_valid(load_rsp_valid)
);

/* sim/tb_mem_rd.sv */
`timescale 1ns/1ps

module tb_mem_rd;

    localparam int MEM_WORDS   = 256;
    localparam int REQ_DEPTH   = 4;
    localparam int RSP_CREDITS = 2;

    logic                       clk;
    logic                       rst_n;
    logic                       fetch_req_valid;
    logic [63:0]                fetch_req_pc;
    logic                       fetch_req_credit;
    logic                       load_req_valid;
    logic [63:0]                load_req_addr;
    memrd_pkg::mem_op_e         load_req_op;
    logic                       load_req_credit;
    logic                       fetch_rsp_valid;
    logic [31:0]                fetch_rsp_instr;
    logic                       fetch_rsp_error;
    logic                       fetch_rsp_credit;
    logic                       load_rsp_valid;
    logic [63:0]                load_rsp_data;
    logic                       load_rsp_error;
    logic                       load_rsp_credit;
    logic                       mem_wr_en;
    logic [63:0]                mem_wr_addr;
    logic [63:0]                mem_wr_data;

    logic [63:0]                model_mem [MEM_WORDS];  // reference copy of the array
    logic [63:0]                wr_idx_q[$];
    logic [63:0]                wr_data_q[$];
    logic [63:0]                fetch_pc_q[$];
    logic [63:0]                load_addr_q[$];
    memrd_pkg::mem_op_e         load_op_q[$];
    logic [64:0]                fetch_exp_q[$];  // {error, data}
    logic [64:0]                load_exp_q[$];
    int                         fetch_due_q[$];  // cycle to hand back a response credit
    int                         load_due_q[$];
    int                         fetch_credits;
    int                         load_credits;
    int                         cycle;
    int                         cycle_limit;
    logic [15:0]                lfsr;

    mem_rd_top #(
        .MEM_WORDS(MEM_WORDS), .REQ_DEPTH(REQ_DEPTH), .RSP_CREDITS(RSP_CREDITS)
    ) u_dut (
        .clk(clk), .rst_n(rst_n),
        .fetch_req_valid(fetch_req_valid), .fetch_req_pc(fetch_req_pc),
        .fetch_req_credit(fetch_req_credit),
        .load_req_valid(load_req_valid), .load_req_addr(load_req_addr),
        .load_req_op(load_req_op), .load_req_credit(load_req_credit),
        .fetch_rsp_valid(fetch_rsp_valid), .fetch_rsp_instr(fetch_rsp_instr),
        .fetch_rsp_error(fetch_rsp_error), .fetch_rsp_credit(fetch_rsp_credit),
        .load_rsp_valid(load_rsp_valid), .load_rsp_data(load_rsp_data),
        .load_rsp_error(load_rsp_error), .load_rsp_credit(load_rsp_credit),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            fail_run("timeout: requests or responses still outstanding at the cycle limit");
        end
    end

    // ########################################
    // reference rules
    // ########################################
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // delay of 0 to 3 cycles built from two single step bits
    task automatic draw_delay(output int delay);
        delay = 0;
        for (int i = 0; i < 2; i++) begin
            delay = (delay << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [64:0] fetch_expect(input logic [63:0] pc);
        logic [63:0] word;
        if (pc[63:3] >= MEM_WORDS) begin
            return {1'b1, 64'h0};
        end
        word = model_mem[int'(pc >> 3)];
        return {1'b0, 32'h0, (pc[2] ? word[63:32] : word[31:0])};
    endfunction

    function automatic logic [64:0] load_expect(input logic [63:0] addr, input logic [2:0] op);
        logic [63:0] word;
        logic [63:0] mask;
        logic [63:0] value;
        int          shift;
        if (addr[63:3] >= MEM_WORDS) begin
            return {1'b1, 64'h0};
        end
        word = model_mem[int'(addr >> 3)];
        case (op[1:0])
            2'd0:    shift = 8 * addr[2:0];   // byte at its exact offset
            2'd1:    shift = 16 * addr[2:1];
            2'd2:    shift = 32 * addr[2];
            default: shift = 0;
        endcase
        mask  = (op[1:0] == 2'd3) ? '1 : ((64'd1 << (8 << op[1:0])) - 64'd1);
        value = (word >> shift) & mask;
        if (!op[2] && value[(8 << op[1:0]) - 1]) begin
            value = value | ~mask;  // sign fill above the lane
        end
        return {1'b0, value};
    endfunction

    // ########################################
    // cases file
    // ########################################
    task automatic read_cases(output int n_cases);
        int                 fd;
        logic [8*128-1:0]   line;
        logic [8*8-1:0]     tag;
        logic [8*8-1:0]     op_name;
        logic [63:0]        a;
        logic [63:0]        b;
        memrd_pkg::mem_op_e op;
        n_cases = 0;
        fd = $fopen("sim/mem_rd_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open sim/mem_rd_cases.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            tag  = '0;
            if ($fgets(line, fd) == 0) break;
            if ($sscanf(line, "%s", tag) < 1 || tag == "#") continue;
            if (tag == "W") begin
                void'($sscanf(line, "%s %h %h", tag, a, b));
                wr_idx_q.push_back(a);
                wr_data_q.push_back(b);
                n_cases++;
            end else if (tag == "F") begin
                void'($sscanf(line, "%s %h %h", tag, a, b));
                for (int i = 0; i < int'(b); i++) fetch_pc_q.push_back(a + 64'(4 * i));
                n_cases += int'(b);
            end else if (tag == "L") begin
                void'($sscanf(line, "%s %s %h %h", tag, op_name, a, b));
                case (op_name)
                    "lb":    op = memrd_pkg::lb;
                    "lh":    op = memrd_pkg::lh;
                    "lw":    op = memrd_pkg::lw;
                    "ld":    op = memrd_pkg::ld;
                    "lbu":   op = memrd_pkg::lbu;
                    "lhu":   op = memrd_pkg::lhu;
                    "lwu":   op = memrd_pkg::lwu;
                    default: fail_run("unknown load op in the cases file");
                endcase
                for (int i = 0; i < int'(b); i++) begin
                    load_addr_q.push_back(a + 64'(i));
                    load_op_q.push_back(op);
                end
                n_cases += int'(b);
            end else begin
                fail_run("unknown record type in the cases file");
            end
        end
        $fclose(fd);
    endtask

    // ########################################
    // stimulus
    // ########################################
    task automatic apply_preload();
        while (wr_idx_q.size() > 0) begin
            mem_wr_en   = 1'b1;
            mem_wr_addr = wr_idx_q.pop_front();
            mem_wr_data = wr_data_q.pop_front();
            if (mem_wr_addr < MEM_WORDS) model_mem[int'(mem_wr_addr)] = mem_wr_data;
            @(posedge clk);
            #2;
        end
        mem_wr_en = 1'b0;
    endtask

    task automatic run_traffic();
        int          delay;
        logic [64:0] want;
        while (fetch_pc_q.size() > 0 || load_addr_q.size() > 0 ||
               fetch_exp_q.size() > 0 || load_exp_q.size() > 0) begin
            // outputs are settled 2 ns after the edge
            if (fetch_rsp_valid) begin
                if (fetch_exp_q.size() == 0) fail_run("fetch response with none outstanding");
                want = fetch_exp_q.pop_front();
                compare_value("fetch_rsp_error", 64'(fetch_rsp_error), 64'(want[64]));
                compare_value("fetch_rsp_instr", 64'(fetch_rsp_instr), want[63:0]);
                draw_delay(delay);
                fetch_due_q.push_back(cycle + delay);
            end
            if (load_rsp_valid) begin
                if (load_exp_q.size() == 0) fail_run("load response with none outstanding");
                want = load_exp_q.pop_front();
                compare_value("load_rsp_error", 64'(load_rsp_error), 64'(want[64]));
                compare_value("load_rsp_data", load_rsp_data, want[63:0]);
                draw_delay(delay);
                load_due_q.push_back(cycle + delay);
            end
            if (fetch_req_credit) fetch_credits++;
            if (load_req_credit) load_credits++;

            fetch_req_valid = 1'b0;
            load_req_valid  = 1'b0;
            if (fetch_pc_q.size() > 0 && fetch_credits > 0) begin
                fetch_req_valid = 1'b1;
                fetch_req_pc    = fetch_pc_q.pop_front();
                fetch_exp_q.push_back(fetch_expect(fetch_req_pc));
                fetch_credits--;
            end
            if (load_addr_q.size() > 0 && load_credits > 0) begin
                load_req_valid = 1'b1;
                load_req_addr  = load_addr_q.pop_front();
                load_req_op    = load_op_q.pop_front();
                load_exp_q.push_back(load_expect(load_req_addr, load_req_op));
                load_credits--;
            end
            // at most one credit per cycle per channel and the oldest first
            fetch_rsp_credit = fetch_due_q.size() > 0 && fetch_due_q[0] <= cycle;
            if (fetch_rsp_credit) void'(fetch_due_q.pop_front());
            load_rsp_credit = load_due_q.size() > 0 && load_due_q[0] <= cycle;
            if (load_rsp_credit) void'(load_due_q.pop_front());
            @(posedge clk);
            #2;
        end
        fetch_rsp_credit = 1'b0;
        load_rsp_credit  = 1'b0;
    endtask

    initial begin
        int n_cases;
        clk              = 1'b0;
        rst_n            = 1'b0;
        fetch_req_valid  = 1'b0;
        fetch_req_pc     = '0;
        load_req_valid   = 1'b0;
        load_req_addr    = '0;
        load_req_op      = memrd_pkg::lb;
        fetch_rsp_credit = 1'b0;
        load_rsp_credit  = 1'b0;
        mem_wr_en        = 1'b0;
        mem_wr_addr      = '0;
        mem_wr_data      = '0;
        lfsr             = 16'd56371;
        fetch_credits    = REQ_DEPTH;
        load_credits     = REQ_DEPTH;
        read_cases(n_cases);
        cycle_limit = 20 * n_cases + 200;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        apply_preload();
        run_traffic();
        compare_value("fetch_req_credit total", 64'(fetch_credits), 64'(REQ_DEPTH));
        compare_value("load_req_credit total", 64'(load_credits), 64'(REQ_DEPTH));
        // a duplicate would show up as a stray response here
        repeat (4) begin
            if (fetch_rsp_valid || load_rsp_valid) begin
                fail_run("response seen after every expected response was taken");
            end
            @(posedge clk);
            #2;
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb.f */
rtl/memrd_pkg.sv
rtl/req_fifo.sv
rtl/rd_ctrl.sv
rtl/mem_array.sv
rtl/rsp_format.sv
rtl/mem_rd_top.sv
sim/mem_rd_checker.sv
sim/tb_mem_rd.sv
